//--- audio_macros.svh
`ifndef AUDIO_MACROS_SVH
`define AUDIO_MACROS_SVH

// sample format
`define AUDIO_WIDTH 16
`define AUDIO_MAX 16'sh7fff
`define AUDIO_MIN 16'sh8000

// calibration block of 2**15 samples
`define OFFSET_LOG2_SAMPLES 15
`define ACC_WIDTH 36

// command word fields
`define OPCODE_WIDTH 4
`define MANUAL_OFFSET_WIDTH 12

// gain is unsigned q4.8
`define GAIN_WIDTH 12
`define GAIN_FRAC_BITS 8
`define GAIN_UNITY 256

`endif

//--- audio_sample_pkg.sv
`default_nettype none

`include "audio_macros.svh"

package audio_sample_pkg;

    // one pcm sample in two's complement
    typedef logic signed [`AUDIO_WIDTH-1:0] sample_t;

    typedef logic signed [`ACC_WIDTH-1:0] acc_t;  // holds a full block of full-scale samples

    typedef logic [`GAIN_WIDTH-1:0] gain_t;  // 256 means a gain of exactly one

endpackage

`default_nettype wire

//--- audio_cmd_pkg.sv
`default_nettype none

`include "audio_macros.svh"

package audio_cmd_pkg;

    typedef enum logic [`OPCODE_WIDTH-1:0] {
        OP_NOP        = 4'd0,
        OP_CALIBRATE  = 4'd1,
        OP_SET_OFFSET = 4'd2,
        OP_SET_GAIN   = 4'd3
    } opcode_e;

    // both views keep the opcode in the top nibble, only the argument differs
    typedef union packed {
        struct packed {
            opcode_e                                opcode;
            logic signed [`MANUAL_OFFSET_WIDTH-1:0] offset;
        } offset_view;
        struct packed {
            opcode_e                 opcode;
            audio_sample_pkg::gain_t gain;
        } gain_view;
    } cmd_word_u;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_CALIBRATING,
        CTRL_LOAD  // first cycle with the measured offset in place
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- calculate_offset.sv
`default_nettype none

`include "audio_macros.svh"

module calculate_offset (
    input  wire                              audio_clk,
    input  wire                              rst_in,
    input  wire                              audio_trigger,
    input  wire                              offset_trigger,
    input  wire audio_sample_pkg::sample_t   audio_in,
    output audio_sample_pkg::sample_t        offset,
    output logic                             offset_produced
);

    typedef enum logic [1:0] {
        OFS_WAIT,
        OFS_ACCUMULATE,
        OFS_COMPUTE
    } ofs_state_e;

    ofs_state_e state;
    audio_sample_pkg::acc_t sum;
    logic [`OFFSET_LOG2_SAMPLES:0] count;  // one spare bit flags a full block

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            state <= OFS_WAIT;
            count <= '0;
            offset_produced <= 1'b0;
        end else begin
            offset_produced <= 1'b0;
            case (state)
                OFS_WAIT: begin
                    sum <= '0;
                    count <= '0;
                    if (offset_trigger) begin
                        state <= OFS_ACCUMULATE;
                    end
                end
                OFS_ACCUMULATE: begin
                    if (audio_trigger) begin
                        if (count[`OFFSET_LOG2_SAMPLES]) begin
                            state <= OFS_COMPUTE;  // the closing strobe is not summed
                        end else begin
                            sum <= sum + audio_sample_pkg::acc_t'(audio_in);
                            count <= count + 1'b1;
                        end
                    end
                end
                OFS_COMPUTE: begin
                    // dividing by the power-of-two block length gives the mean
                    offset <= audio_sample_pkg::sample_t'(sum >>> `OFFSET_LOG2_SAMPLES);
                    offset_produced <= 1'b1;
                    state <= OFS_WAIT;
                end
                default: begin
                    state <= OFS_WAIT;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- audio_ctrl.sv
`default_nettype none

`include "audio_macros.svh"

module audio_ctrl (
    input  wire                              audio_clk,
    input  wire                              rst_in,
    input  wire                              cmd_strobe,
    input  wire audio_cmd_pkg::cmd_word_u    cmd_word,
    input  wire audio_sample_pkg::sample_t   offset,
    input  wire                              offset_produced,
    output logic                             offset_trigger,
    output logic                             busy,
    output logic                             cmd_error,
    output audio_sample_pkg::sample_t        active_offset,
    output audio_sample_pkg::gain_t          gain
);

    audio_cmd_pkg::ctrl_state_e state;
    logic signed [`MANUAL_OFFSET_WIDTH-1:0] manual_offset;

    assign busy = (state == audio_cmd_pkg::CTRL_CALIBRATING);
    assign manual_offset = cmd_word.offset_view.offset;

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            state <= audio_cmd_pkg::CTRL_IDLE;
            offset_trigger <= 1'b0;
            cmd_error <= 1'b0;
            active_offset <= '0;
            gain <= `GAIN_UNITY;
        end else begin
            offset_trigger <= 1'b0;
            cmd_error <= 1'b0;
            case (state)
                audio_cmd_pkg::CTRL_CALIBRATING: begin
                    if (offset_produced) begin
                        active_offset <= offset;
                        state <= audio_cmd_pkg::CTRL_LOAD;
                    end
                    cmd_error <= cmd_strobe;  // nothing is taken until the measurement lands
                end
                default: begin
                    state <= audio_cmd_pkg::CTRL_IDLE;
                    if (cmd_strobe) begin
                        // the opcode sits in the same bits of both views
                        case (cmd_word.offset_view.opcode)
                            audio_cmd_pkg::OP_NOP: ;
                            audio_cmd_pkg::OP_CALIBRATE: begin
                                offset_trigger <= 1'b1;
                                state <= audio_cmd_pkg::CTRL_CALIBRATING;
                            end
                            audio_cmd_pkg::OP_SET_OFFSET: begin
                                active_offset <= audio_sample_pkg::sample_t'(manual_offset);
                            end
                            audio_cmd_pkg::OP_SET_GAIN: begin
                                gain <= cmd_word.gain_view.gain;
                            end
                            default: begin
                                cmd_error <= 1'b1;
                            end
                        endcase
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- offset_remover.sv
`default_nettype none

`include "audio_macros.svh"

module offset_remover (
    input  wire                              audio_clk,
    input  wire                              rst_in,
    input  wire                              audio_trigger,
    input  wire audio_sample_pkg::sample_t   audio_in,
    input  wire audio_sample_pkg::sample_t   active_offset,
    output audio_sample_pkg::sample_t        clean_sample,
    output logic                             clean_valid,
    output logic                             clean_sat
);

    logic signed [`AUDIO_WIDTH:0] diff;
    logic diff_sat;
    audio_sample_pkg::sample_t diff_clamped;

    // one guard bit is enough for the difference of two samples
    assign diff = {audio_in[`AUDIO_WIDTH-1], audio_in}
                - {active_offset[`AUDIO_WIDTH-1], active_offset};
    assign diff_sat = diff[`AUDIO_WIDTH] ^ diff[`AUDIO_WIDTH-1];  // top bits disagree when out of range

    always_comb begin
        if (!diff_sat) begin
            diff_clamped = diff[`AUDIO_WIDTH-1:0];
        end else if (diff[`AUDIO_WIDTH]) begin
            diff_clamped = `AUDIO_MIN;
        end else begin
            diff_clamped = `AUDIO_MAX;
        end
    end

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            clean_valid <= 1'b0;
        end else begin
            clean_valid <= audio_trigger;
        end
    end

    always_ff @(posedge audio_clk) begin
        if (audio_trigger) begin
            clean_sample <= diff_clamped;
            clean_sat <= diff_sat;
        end
    end

endmodule

`default_nettype wire

//--- gain_stage.sv
`default_nettype none

`include "audio_macros.svh"

module gain_stage (
    input  wire                              audio_clk,
    input  wire                              rst_in,
    input  wire audio_sample_pkg::sample_t   clean_sample,
    input  wire                              clean_valid,
    input  wire                              clean_sat,
    input  wire audio_sample_pkg::gain_t     gain,
    output audio_sample_pkg::sample_t        audio_out,
    output logic                             audio_out_valid,
    output logic                             clip
);

    // signed sample times gain with a zero sign bit on top
    localparam int PROD_WIDTH = `AUDIO_WIDTH + `GAIN_WIDTH + 1;

    logic signed [PROD_WIDTH-1:0] product;
    logic signed [PROD_WIDTH-1:0] scaled;
    logic [PROD_WIDTH-`AUDIO_WIDTH:0] head;
    logic over;
    audio_sample_pkg::sample_t clamped;

    assign product = clean_sample * $signed({1'b0, gain});
    assign scaled = product >>> `GAIN_FRAC_BITS;

    // the result fits when every bit above the sample's msb copies the sign
    assign head = scaled[PROD_WIDTH-1:`AUDIO_WIDTH-1];
    assign over = !((&head) || !(|head));

    always_comb begin
        if (!over) begin
            clamped = scaled[`AUDIO_WIDTH-1:0];
        end else if (scaled[PROD_WIDTH-1]) begin
            clamped = `AUDIO_MIN;
        end else begin
            clamped = `AUDIO_MAX;
        end
    end

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            audio_out_valid <= 1'b0;
        end else begin
            audio_out_valid <= clean_valid;
        end
    end

    always_ff @(posedge audio_clk) begin
        if (clean_valid) begin
            audio_out <= clamped;
            clip <= over | clean_sat;  // a clamp in either stage counts
        end
    end

endmodule

`default_nettype wire

//--- audio_channel_top.sv
`default_nettype none

module audio_channel_top (
    input  wire                              audio_clk,
    input  wire                              rst_in,
    input  wire                              audio_trigger,
    input  wire audio_sample_pkg::sample_t   audio_in,
    input  wire                              cmd_strobe,
    input  wire audio_cmd_pkg::cmd_word_u    cmd_word,
    output wire audio_sample_pkg::sample_t   audio_out,
    output wire                              audio_out_valid,
    output wire                              clip,
    output wire                              busy,
    output wire                              cmd_error,
    output wire audio_sample_pkg::sample_t   active_offset
);

    logic offset_trigger;
    logic offset_produced;
    audio_sample_pkg::sample_t offset;
    audio_sample_pkg::gain_t gain;
    audio_sample_pkg::sample_t clean_sample;
    logic clean_valid;
    logic clean_sat;

    audio_ctrl audio_ctrl_i (
        .audio_clk       (audio_clk),
        .rst_in          (rst_in),
        .cmd_strobe      (cmd_strobe),
        .cmd_word        (cmd_word),
        .offset          (offset),
        .offset_produced (offset_produced),
        .offset_trigger  (offset_trigger),
        .busy            (busy),
        .cmd_error       (cmd_error),
        .active_offset   (active_offset),
        .gain            (gain)
    );

    calculate_offset calculate_offset_i (
        .audio_clk       (audio_clk),
        .rst_in          (rst_in),
        .audio_trigger   (audio_trigger),
        .offset_trigger  (offset_trigger),
        .audio_in        (audio_in),
        .offset          (offset),
        .offset_produced (offset_produced)
    );

    offset_remover offset_remover_i (
        .audio_clk     (audio_clk),
        .rst_in        (rst_in),
        .audio_trigger (audio_trigger),
        .audio_in      (audio_in),
        .active_offset (active_offset),
        .clean_sample  (clean_sample),
        .clean_valid   (clean_valid),
        .clean_sat     (clean_sat)
    );

    gain_stage gain_stage_i (
        .audio_clk       (audio_clk),
        .rst_in          (rst_in),
        .clean_sample    (clean_sample),
        .clean_valid     (clean_valid),
        .clean_sat       (clean_sat),
        .gain            (gain),
        .audio_out       (audio_out),
        .audio_out_valid (audio_out_valid),
        .clip            (clip)
    );

endmodule

`default_nettype wire

//--- audio_channel_properties.sv
`default_nettype none

module audio_channel_properties (
    input wire audio_clk,
    input wire rst_in,
    input wire audio_trigger,
    input wire audio_out_valid,
    input wire cmd_error,
    input wire busy,
    input wire offset_produced
);

    // two register stages sit between the input strobe and the output
    valid_latency: assert property (@(posedge audio_clk) disable iff (rst_in)
        audio_out_valid == $past(audio_trigger, 2))
        else $error("audio_out_valid does not follow audio_trigger by two cycles");

    error_pulse: assert property (@(posedge audio_clk) disable iff (rst_in)
        cmd_error |-> !$past(cmd_error))
        else $error("cmd_error stayed high for more than one cycle");

    busy_release: assert property (@(posedge audio_clk) disable iff (rst_in)
        $fell(busy) |-> $past(offset_produced))
        else $error("busy fell without an offset_produced pulse one cycle earlier");

    busy_after_reset: assert property (@(posedge audio_clk)
        $past(rst_in) |-> !busy)
        else $error("busy is high after reset");

endmodule

bind audio_channel_top audio_channel_properties audio_channel_properties_i (
    .audio_clk       (audio_clk),
    .rst_in          (rst_in),
    .audio_trigger   (audio_trigger),
    .audio_out_valid (audio_out_valid),
    .cmd_error       (cmd_error),
    .busy            (busy),
    .offset_produced (offset_produced)
);

`default_nettype wire

//--- audio_channel_tb.sv
`default_nettype none

`include "audio_macros.svh"

module audio_channel_tb;

    localparam int CAL_BLOCK = 1 << `OFFSET_LOG2_SAMPLES;
    // two calibrations at a 3/4 strobe rate take about 88k cycles and the rest a few thousand
    localparam int MAX_CYCLES = 300000;

    logic audio_clk;
    logic rst_in;
    logic audio_trigger;
    audio_sample_pkg::sample_t audio_in;
    logic cmd_strobe;
    logic [15:0] cmd_word;
    audio_sample_pkg::sample_t audio_out;
    logic audio_out_valid;
    logic clip;
    logic busy;
    logic cmd_error;
    audio_sample_pkg::sample_t active_offset;

    integer seed;
    int cycle_count;
    int errors;
    int checks;
    int clip_count;
    int errors_before;
    int bias;
    logic [3:0] bad_op;
    logic reported;

    audio_sample_pkg::sample_t model_offset;
    audio_sample_pkg::gain_t model_gain;
    logic model_busy;
    logic exp_cmd_error;
    int cal_phase;  // 0 idle, 1 averager arming, 2 summing, 3 waiting for the load
    int cal_count;
    int cal_wait;
    longint cal_sum;
    logic [16:0] exp_q[$];  // clip flag sits above the expected sample

    audio_channel_top audio_channel_top_i (
        .audio_clk       (audio_clk),
        .rst_in          (rst_in),
        .audio_trigger   (audio_trigger),
        .audio_in        (audio_in),
        .cmd_strobe      (cmd_strobe),
        .cmd_word        (cmd_word),
        .audio_out       (audio_out),
        .audio_out_valid (audio_out_valid),
        .clip            (clip),
        .busy            (busy),
        .cmd_error       (cmd_error),
        .active_offset   (active_offset)
    );

    always #5 audio_clk = ~audio_clk;

    always @(posedge audio_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the test sequence did not complete", cycle_count);
            reported = 1'b1;
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic report_value(input string name, input logic signed [31:0] expected,
                                input logic signed [31:0] actual);
        errors++;
        $display("FAILED time=%0t %s: expected %0d, got %0d", $time, name, expected, actual);
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("ERROR time=%0t %s", $time, what);
    endtask

    function automatic logic [16:0] expected_output(input audio_sample_pkg::sample_t sample,
                                                    input audio_sample_pkg::sample_t ofs,
                                                    input audio_sample_pkg::gain_t g);
        int diff;
        int scaled;
        logic sat;
        logic over;
        diff = int'(sample) - int'(ofs);
        sat = (diff > 32767) || (diff < -32768);
        if (diff > 32767)
            diff = 32767;
        else if (diff < -32768)
            diff = -32768;
        scaled = (diff * int'(g)) >>> `GAIN_FRAC_BITS;  // q4.8 product back to sample scale
        over = (scaled > 32767) || (scaled < -32768);
        if (scaled > 32767)
            scaled = 32767;
        else if (scaled < -32768)
            scaled = -32768;
        return {sat | over, scaled[15:0]};
    endfunction

    function automatic logic random_trigger();
        return ($random(seed) & 3) != 0;  // strobes on about 3 of 4 cycles
    endfunction

    function automatic audio_sample_pkg::sample_t random_sample();
        int r;
        r = $random(seed);
        if (r[31:30] != 2'b00)
            return audio_sample_pkg::sample_t'(r[15:0]);
        if (r[29])
            return audio_sample_pkg::sample_t'(32767 - int'(r[7:0]));  // push toward clamping
        return audio_sample_pkg::sample_t'(-32768 + int'(r[7:0]));
    endfunction

    task automatic check_outputs();
        logic [16:0] expected;
        if (cmd_error !== exp_cmd_error)
            report_value("cmd_error", exp_cmd_error, cmd_error);
        if (busy !== model_busy)
            report_value("busy", model_busy, busy);
        if (active_offset !== model_offset)
            report_value("active_offset", model_offset, active_offset);
        if (audio_out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                report_problem("audio_out_valid is high with no sample in flight");
            end else begin
                expected = exp_q.pop_front();
                checks++;
                if (audio_out !== expected[15:0])
                    report_value("audio_out", $signed(expected[15:0]), audio_out);
                if (clip !== expected[16])
                    report_value("clip", expected[16], clip);
            end
        end else if (audio_out_valid !== 1'b0) begin
            report_problem("audio_out_valid is unknown");
        end
    endtask

    // drives one cycle on the falling edge and keeps the model in step with the DUT
    task automatic step(input logic trig, input audio_sample_pkg::sample_t sample,
                        input logic strobe, input logic [15:0] word);
        @(negedge audio_clk);
        if (cal_phase == 3) begin
            cal_wait--;
            if (cal_wait == 0) begin
                model_offset = audio_sample_pkg::sample_t'(cal_sum >>> `OFFSET_LOG2_SAMPLES);
                model_busy = 1'b0;
                cal_phase = 0;
            end
        end
        check_outputs();
        audio_trigger = trig;
        audio_in = sample;
        cmd_strobe = strobe;
        cmd_word = word;
        if (trig) begin
            exp_q.push_back(expected_output(sample, model_offset, model_gain));
            clip_count += int'(exp_q[$][16]);
        end
        if (cal_phase == 1) begin
            cal_phase = 2;  // the averager is still waiting when this cycle is sampled
        end else if (cal_phase == 2 && trig) begin
            if (cal_count < CAL_BLOCK) begin
                cal_sum = cal_sum + longint'(sample);
                cal_count++;
            end else begin
                cal_phase = 3;  // the closing strobe makes the load land three cycles on
                cal_wait = 3;
            end
        end
        exp_cmd_error = 1'b0;
        if (strobe && model_busy) begin
            exp_cmd_error = 1'b1;
        end else if (strobe) begin
            case (word[15:12])
                audio_cmd_pkg::OP_NOP: ;
                audio_cmd_pkg::OP_CALIBRATE: begin
                    model_busy = 1'b1;
                    cal_phase = 1;
                    cal_count = 0;
                    cal_sum = 0;
                end
                audio_cmd_pkg::OP_SET_OFFSET:
                    model_offset = audio_sample_pkg::sample_t'($signed(word[11:0]));
                audio_cmd_pkg::OP_SET_GAIN:
                    model_gain = word[11:0];
                default:
                    exp_cmd_error = 1'b1;
            endcase
        end
    endtask

    task automatic run_samples(input int count);
        logic trig;
        audio_sample_pkg::sample_t sample;
        repeat (count) begin
            trig = random_trigger();
            sample = random_sample();
            step(trig, sample, 1'b0, 16'h0000);
        end
    endtask

    // drives a constant bias plus small noise and stops early once a calibration has landed
    task automatic run_biased(input int level, input int count);
        audio_sample_pkg::sample_t sample;
        int n;
        n = 0;
        while (cal_phase != 0 && n < count) begin
            sample = audio_sample_pkg::sample_t'(level + ($random(seed) % 64));
            step(random_trigger(), sample, 1'b0, 16'h0000);
            n++;
        end
    endtask

    task automatic send_command(input logic [15:0] word);
        step(1'b0, random_sample(), 1'b1, word);
        step(1'b0, random_sample(), 1'b0, 16'h0000);  // gap keeps error pulses apart
    endtask

    task automatic finish_test(input int num, input string name);
        repeat (3)
            step(1'b0, random_sample(), 1'b0, 16'h0000);
        if (exp_q.size() != 0)
            report_problem($sformatf("%0d expected outputs never appeared", exp_q.size()));
        exp_q.delete();
        $display("test %0d %s done: %0d errors, %0d clipped samples", num, name,
                 errors - errors_before, clip_count);
        errors_before = errors;
        clip_count = 0;
    endtask

    initial begin
        seed = 32'h2ff8_7161;
        audio_clk = 1'b0;
        rst_in = 1'b1;
        audio_trigger = 1'b0;
        audio_in = '0;
        cmd_strobe = 1'b0;
        cmd_word = 16'h0000;
        cycle_count = 0;
        errors = 0;
        checks = 0;
        clip_count = 0;
        errors_before = 0;
        reported = 1'b0;
        model_offset = '0;
        model_gain = `GAIN_UNITY;
        model_busy = 1'b0;
        exp_cmd_error = 1'b0;
        cal_phase = 0;
        cal_count = 0;
        cal_wait = 0;
        cal_sum = 0;
        repeat (4) @(posedge audio_clk);
        @(negedge audio_clk);
        rst_in = 1'b0;

        run_samples(300);
        finish_test(1, "reset and pass-through");

        repeat (4) begin
            send_command({audio_cmd_pkg::OP_SET_OFFSET, 12'($random(seed))});
            run_samples(150);
        end
        finish_test(2, "manual offset");

        for (int round = 0; round < 5; round++) begin
            send_command({audio_cmd_pkg::OP_SET_GAIN, 1'(round < 2) | 1'($random(seed)),
                          11'($random(seed))});
            run_samples(150);
        end
        send_command({audio_cmd_pkg::OP_SET_GAIN, 12'(`GAIN_UNITY)});
        finish_test(3, "gain");

        bias = $random(seed) % 8000;
        send_command({audio_cmd_pkg::OP_CALIBRATE, 12'h000});
        run_biased(bias, MAX_CYCLES);
        run_samples(200);
        finish_test(4, "calibration");

        send_command({audio_cmd_pkg::OP_NOP, 12'($random(seed))});
        repeat (4) begin
            bad_op = 4'(4 + {$random(seed)} % 12);
            send_command({bad_op, 12'($random(seed))});
            run_samples(20);
        end
        bias = $random(seed) % 8000;
        send_command({audio_cmd_pkg::OP_CALIBRATE, 12'h000});
        run_biased(bias, 200);
        send_command({audio_cmd_pkg::OP_SET_OFFSET, 12'($random(seed))});
        run_biased(bias, 50);
        send_command({audio_cmd_pkg::OP_SET_GAIN, 12'($random(seed))});
        run_biased(bias, 50);
        send_command({audio_cmd_pkg::OP_CALIBRATE, 12'h000});
        send_command({audio_cmd_pkg::OP_NOP, 12'h000});
        run_biased(bias, MAX_CYCLES);
        run_samples(100);
        finish_test(5, "command errors");

        $display("5 tests run, %0d outputs checked, %0d errors", checks, errors);
        reported = 1'b1;
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    // catches a run that ends without the closing report
    final begin
        if (!reported) begin
            $display("simulation ended before the closing report");
            $display("RESULT: FAIL");
        end
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+.
audio_sample_pkg.sv
audio_cmd_pkg.sv
calculate_offset.sv
audio_ctrl.sv
offset_remover.sv
gain_stage.sv
audio_channel_top.sv
audio_channel_properties.sv
audio_channel_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the audio channel testbench with verilator, runs it and checks the log

set -u
cd "$(dirname "$0")" || exit 1

log_file=sim.log
sim_binary=audio_channel_sim

verilator --binary --timing --assert -Wno-fatal \
    --top-module audio_channel_tb -f all.f -o "$sim_binary"
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/"$sim_binary" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "RESULT: PASS" "$log_file"; then
    echo "simulation passed"
    exit 0
fi

echo "pass message not found in $log_file"
exit 1
